// ==== common/plru_pkg.sv ====
package plru_pkg;

  // --------------------
  // tlb geometry
  // --------------------
  localparam int NUM_ENTRY  = 32;
  localparam int TREE_DEPTH = $clog2(NUM_ENTRY);
  localparam int NUM_NODE   = NUM_ENTRY - 1;
  localparam int NODE_IDX_W = $clog2(NUM_NODE);

  // one bit per entry
  typedef logic [NUM_ENTRY-1:0]  entry_onehot_t;
  typedef logic [TREE_DEPTH-1:0] entry_idx_t;

  // direction bits in heap order, node 0 is the root
  // children of node n sit at 2n+1 (lower) and 2n+2 (upper)
  typedef logic [NUM_NODE-1:0]   node_vec_t;
  typedef logic [NODE_IDX_W-1:0] node_idx_t;

  // --------------------
  // tree path helper
  // --------------------
  // node visited at level lvl on the way to entry idx
  // only the top lvl bits of idx matter here
  function automatic node_idx_t path_node(input int lvl, input entry_idx_t idx);
    node_idx_t lvl_base;
    node_idx_t lvl_offs;
    lvl_base = node_idx_t'((1 << lvl) - 1);
    lvl_offs = node_idx_t'(idx >> (TREE_DEPTH - lvl));
    return lvl_base + lvl_offs;
  endfunction

endpackage

// ==== plru_tree/plru_tree_state.sv ====
module plru_tree_state
  import plru_pkg::*;
(
  input  logic       w_dff4_fire,
  input  logic       cpurst_b,
  input  logic       i_updt_vld,
  input  entry_idx_t i_updt_idx,
  output node_vec_t  o_node_bits
);

  node_vec_t node_q;
  node_vec_t node_d;

  //                P00
  //              0/   \1
  //           P10       P11
  //          /  \      /  \
  //        P20  P21  P22  P23
  //         ...   P30..P37   ...
  //         ...   P40..P4F   ...
  // P00 is node 0, P4F is node 30

  // --------------------
  // path update
  // --------------------
  // every node on the path points away from the used entry
  // 1 when the entry sits in the lower half of that node
  always_comb
  begin
    node_d = node_q;
    if (i_updt_vld)
    begin
      for (int lvl = 0; lvl < TREE_DEPTH; lvl++)
      begin
        node_d[path_node(lvl, i_updt_idx)] = ~i_updt_idx[TREE_DEPTH-1-lvl];
      end
    end
  end

  // --------------------
  // direction bits
  // --------------------
  always_ff @(posedge w_dff4_fire or negedge cpurst_b)
  begin
    if (!cpurst_b)
      node_q <= '0;
    else
      node_q <= node_d;
  end

  assign o_node_bits = node_q;

endmodule

// ==== plru_tree/plru_victim_walk.sv ====
module plru_victim_walk
  import plru_pkg::*;
(
  input  node_vec_t     i_node_bits,
  output entry_onehot_t o_victim_onehot
);

  entry_idx_t vic_idx;

  // --------------------
  // root to leaf walk
  // --------------------
  // each level's direction bit becomes one index bit, msb first
  // bit 1 takes the upper child, bit 0 the lower one
  always_comb
  begin
    vic_idx = '0;
    for (int lvl = 0; lvl < TREE_DEPTH; lvl++)
    begin
      vic_idx[TREE_DEPTH-1-lvl] = i_node_bits[path_node(lvl, vic_idx)];
    end
  end

  // leaf decode
  always_comb
  begin
    o_victim_onehot = '0;
    for (int i = 0; i < NUM_ENTRY; i++)
    begin
      if (vic_idx == entry_idx_t'(i))
        o_victim_onehot[i] = 1'b1;
    end
  end

endmodule

// ==== src/refill_entry_sel.sv ====
module refill_entry_sel
  import plru_pkg::*;
(
  input  entry_onehot_t i_entry_vld,
  input  entry_onehot_t i_victim_onehot,
  output entry_onehot_t o_refill_onehot
);

  entry_onehot_t inv_first;
  logic          any_inv;

  // --------------------
  // lowest invalid entry
  // --------------------
  // priority search from entry 0 upward
  always_comb
  begin
    inv_first = '0;
    any_inv   = 1'b0;
    for (int i = 0; i < NUM_ENTRY; i++)
    begin
      if (!i_entry_vld[i] && !any_inv)
      begin
        inv_first[i] = 1'b1;
        any_inv      = 1'b1;
      end
    end
  end

  // full tlb falls back to the plru victim
  always_comb
  begin
    if (any_inv)
      o_refill_onehot = inv_first;
    else
      o_refill_onehot = i_victim_onehot;
  end

endmodule

// ==== src/plru_access_arb.sv ====
module plru_access_arb
  import plru_pkg::*;
(
  input  logic          w_dff4_fire,
  input  logic          cpurst_b,
  input  logic          i_hit_vld,
  input  entry_onehot_t i_hit_onehot,
  input  logic          i_refill_vld,
  input  entry_onehot_t i_refill_onehot,
  output logic          o_updt_vld,
  output entry_idx_t    o_updt_idx
);

  logic       dfr_vld_q;
  entry_idx_t dfr_idx_q;
  logic       dfr_set;
  logic       dfr_keep;
  entry_idx_t hit_idx;
  entry_idx_t rfl_idx;

  // or-reduce encoder, input is one-hot
  function automatic entry_idx_t onehot_to_idx(input entry_onehot_t onehot);
    entry_idx_t idx;
    idx = '0;
    for (int i = 0; i < NUM_ENTRY; i++)
    begin
      if (onehot[i])
        idx = idx | entry_idx_t'(i);
    end
    return idx;
  endfunction

  assign hit_idx = onehot_to_idx(i_hit_onehot);
  assign rfl_idx = onehot_to_idx(i_refill_onehot);

  // --------------------
  // deferred refill
  // --------------------
  // refill loses to a hit, or queues behind an older deferred one
  assign dfr_set  = i_refill_vld & (i_hit_vld | dfr_vld_q);
  assign dfr_keep = dfr_vld_q & i_hit_vld;

  always_ff @(posedge w_dff4_fire or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dfr_vld_q <= 1'b0;
    else
      dfr_vld_q <= dfr_set | dfr_keep;
  end

  always_ff @(posedge w_dff4_fire)
  begin
    if (dfr_set)
      dfr_idx_q <= rfl_idx;
  end

  // --------------------
  // update select
  // --------------------
  // hit first, then the stored refill, then a fresh one
  assign o_updt_vld = i_hit_vld | dfr_vld_q | i_refill_vld;

  always_comb
  begin
    if (i_hit_vld)
      o_updt_idx = hit_idx;
    else if (dfr_vld_q)
      o_updt_idx = dfr_idx_q;
    else
      o_updt_idx = rfl_idx;
  end

endmodule

// ==== src/plru_top.sv ====
module plru_top
  import plru_pkg::*;
(
  input  logic          w_dff4_fire,
  input  logic          cpurst_b,
  input  entry_onehot_t i_entry_vld,
  input  logic          i_hit_vld,
  input  entry_onehot_t i_hit_onehot,
  input  logic          i_refill_vld,
  output entry_onehot_t o_refill_onehot
);

  logic          updt_vld;
  entry_idx_t    updt_idx;
  node_vec_t     node_bits;
  entry_onehot_t victim_onehot;

  // --------------------
  // tree access
  // --------------------
  // refill strobe carries the target presented this cycle
  plru_access_arb u_access_arb (
    .w_dff4_fire     (w_dff4_fire),
    .cpurst_b        (cpurst_b),
    .i_hit_vld       (i_hit_vld),
    .i_hit_onehot    (i_hit_onehot),
    .i_refill_vld    (i_refill_vld),
    .i_refill_onehot (o_refill_onehot),
    .o_updt_vld      (updt_vld),
    .o_updt_idx      (updt_idx)
  );

  plru_tree_state u_tree_state (
    .w_dff4_fire (w_dff4_fire),
    .cpurst_b    (cpurst_b),
    .i_updt_vld  (updt_vld),
    .i_updt_idx  (updt_idx),
    .o_node_bits (node_bits)
  );

  // --------------------
  // refill target
  // --------------------
  plru_victim_walk u_victim_walk (
    .i_node_bits     (node_bits),
    .o_victim_onehot (victim_onehot)
  );

  refill_entry_sel u_refill_sel (
    .i_entry_vld     (i_entry_vld),
    .i_victim_onehot (victim_onehot),
    .o_refill_onehot (o_refill_onehot)
  );

endmodule

// ==== tb/tb_plru_model.svh ====
`ifndef TB_PLRU_MODEL_SVH
`define TB_PLRU_MODEL_SVH

// model copy of the direction bits and the one-deep refill store
bit [NUM_NODE-1:0] mdl_node;
bit                mdl_dfr_vld;
int                mdl_dfr_entry;

task automatic reset_tree();
  mdl_node      = '0;
  mdl_dfr_vld   = 1'b0;
  mdl_dfr_entry = 0;
endtask

// first set bit of a one-hot, 0 when empty
function automatic int index_of(input entry_onehot_t oh);
  for (int i = 0; i < NUM_ENTRY; i++)
  begin
    if (oh[i])
      return i;
  end
  return 0;
endfunction

// heap walk, node n has children 2n+1 (lower) and 2n+2 (upper)
function automatic int walk_victim();
  int n;
  int entry;
  bit dir;
  n     = 0;
  entry = 0;
  for (int lvl = 0; lvl < TREE_DEPTH; lvl++)
  begin
    dir   = mdl_node[n];
    entry = entry * 2 + int'(dir);
    n     = 2 * n + 1 + int'(dir);
  end
  return entry;
endfunction

function automatic entry_onehot_t predict_target(input entry_onehot_t vld);
  for (int i = 0; i < NUM_ENTRY; i++)
  begin
    if (!vld[i])
      return entry_onehot_t'(1) << i;
  end
  return entry_onehot_t'(1) << walk_victim();
endfunction

// each node on the path points to the other half
task automatic touch_entry(input int entry);
  int n;
  bit dir;
  n = 0;
  for (int lvl = 0; lvl < TREE_DEPTH; lvl++)
  begin
    dir         = bit'((entry >> (TREE_DEPTH - 1 - lvl)) & 1);
    mdl_node[n] = ~dir;
    n           = 2 * n + 1 + int'(dir);
  end
endtask

// hit wins, a stored refill goes next, a fresh one last
task automatic arbitrate(input logic hit, input entry_onehot_t hit_oh,
                         input logic refill, input entry_onehot_t refill_oh);
  if (hit)
  begin
    touch_entry(index_of(hit_oh));
    if (refill)
    begin
      mdl_dfr_vld   = 1'b1;
      mdl_dfr_entry = index_of(refill_oh);
    end
  end
  else if (mdl_dfr_vld)
  begin
    touch_entry(mdl_dfr_entry);
    mdl_dfr_vld = refill;
    if (refill)
      mdl_dfr_entry = index_of(refill_oh);
  end
  else if (refill)
    touch_entry(index_of(refill_oh));
endtask

`endif

// ==== tb/tb_plru.sv ====
module tb_plru
  import plru_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int DRIVE_SKEW  = 2;
  // tests take about 500 cycles
  localparam int CYCLE_LIMIT = 2000;

  logic          clk;
  logic          rst_b;
  entry_onehot_t entry_vld;
  logic          hit_vld;
  entry_onehot_t hit_onehot;
  logic          refill_vld;
  entry_onehot_t refill_onehot;

  integer        seed;
  string         test_name;
  int            cycle_cnt;
  entry_onehot_t seen;
  entry_onehot_t pick;
  logic          last_refill;

  `include "tb_plru_model.svh"

  plru_top uut (
    .w_dff4_fire     (clk),
    .cpurst_b        (rst_b),
    .i_entry_vld     (entry_vld),
    .i_hit_vld       (hit_vld),
    .i_hit_onehot    (hit_onehot),
    .i_refill_vld    (refill_vld),
    .o_refill_onehot (refill_onehot)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic step_clock();
    @(posedge clk);
    #DRIVE_SKEW;
  endtask

  task automatic clear_strobes();
    hit_vld    = 1'b0;
    refill_vld = 1'b0;
  endtask

  // --------------------
  // edge checker
  // --------------------
  always @(posedge clk)
  begin : check_edge
    entry_onehot_t exp_target;
    cycle_cnt  = cycle_cnt + 1;
    exp_target = predict_target(entry_vld);
    if (cycle_cnt > CYCLE_LIMIT)
    begin
      $display("run stopped: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $fatal(1);
    end
    else if (rst_b)
    begin
      assert (refill_onehot === exp_target)
      else
      begin
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp_target,
                 refill_onehot);
        $display("Test FAILED");
        $fatal(1);
      end
      arbitrate(hit_vld, hit_onehot, refill_vld, exp_target);
    end
  end

  // --------------------
  // stimulus
  // --------------------
  initial
  begin
    seed        = 93;
    cycle_cnt   = 0;
    test_name   = "reset";
    rst_b       = 1'b0;
    entry_vld   = '1;
    hit_vld     = 1'b0;
    hit_onehot  = entry_onehot_t'(1);
    refill_vld  = 1'b0;
    seen        = '0;
    pick        = '0;
    last_refill = 1'b0;
    reset_tree();
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_SKEW;
    rst_b = 1'b1;

    assert (refill_onehot === entry_onehot_t'(1))
    else
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", test_name, entry_onehot_t'(1),
               refill_onehot);
      $display("Test FAILED");
      $fatal(1);
    end
    step_clock();

    // entries 5, 9 and 20 start empty and fill lowest first
    test_name = "invalid entries";
    entry_vld = ~entry_onehot_t'(32'h0010_0220);
    for (int k = 0; k < 3; k++)
    begin
      pick       = predict_target(entry_vld);
      refill_vld = 1'b1;
      step_clock();
      entry_vld  = entry_vld | pick;
    end
    refill_vld = 1'b0;
    entry_vld  = '0;
    step_clock();
    entry_vld = '1;
    repeat (2) step_clock();

    test_name = "refill cycle";
    seen      = '0;
    for (int k = 0; k < NUM_ENTRY; k++)
    begin
      assert ($onehot(refill_onehot) && (refill_onehot & seen) == '0)
      else
      begin
        $display("CHECK FAILED %s: expected unused one-hot, actual %h (used %h)",
                 test_name, refill_onehot, seen);
        $display("Test FAILED");
        $fatal(1);
      end
      seen       = seen | refill_onehot;
      refill_vld = 1'b1;
      step_clock();
    end
    refill_vld = 1'b0;
    step_clock();

    test_name = "hit on victim";
    for (int k = 0; k < 8; k++)
    begin
      hit_vld    = 1'b1;
      hit_onehot = predict_target(entry_vld);
      step_clock();
    end
    clear_strobes();
    step_clock();

    // odd rounds keep the hit one more cycle so the store waits
    test_name = "hit with refill";
    for (int k = 0; k < 4; k++)
    begin
      hit_vld    = 1'b1;
      hit_onehot = entry_onehot_t'(1) << ($unsigned($random(seed)) % NUM_ENTRY);
      refill_vld = 1'b1;
      step_clock();
      refill_vld = 1'b0;
      hit_vld    = (k % 2) == 1;
      step_clock();
      hit_vld = 1'b0;
      step_clock();
    end

    test_name = "random mix";
    for (int k = 0; k < 400; k++)
    begin
      hit_vld     = ($random(seed) & 3) == 0;
      hit_onehot  = entry_onehot_t'(1) << ($unsigned($random(seed)) % NUM_ENTRY);
      refill_vld  = !last_refill && (($random(seed) & 1) == 1);
      last_refill = refill_vld;
      if (($random(seed) & 7) == 0)
        entry_vld = entry_onehot_t'($random(seed) | $random(seed));
      else
        entry_vld = '1;
      step_clock();
    end

    clear_strobes();
    entry_vld = '1;
    repeat (2) step_clock();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tb
common/plru_pkg.sv
plru_tree/plru_tree_state.sv
plru_tree/plru_victim_walk.sv
src/refill_entry_sel.sv
src/plru_access_arb.sv
src/plru_top.sv
tb/tb_plru.sv

// ==== Makefile ====
TOP = tb_plru

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module plru_top

sim:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
